// ==== rtl/ctrl_pkg.sv ====
package ctrl_pkg;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR
	} alu_op_t;

	typedef enum logic [1:0] {
		EXT_SIGNED,
		EXT_UNSIGNED,
		EXT_UPPER // immediate goes to the upper half, low half is zero.
	} ext_mode_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC8
	} wb_src_t;

	typedef enum logic [2:0] {
		FWD_D_ORIG,
		FWD_D_E_PC8,
		FWD_D_M_ALU,
		FWD_D_M_PC8,
		FWD_D_W_RES
	} fwd_d_t;

	typedef enum logic [1:0] {
		FWD_E_ORIG,
		FWD_E_M_ALU,
		FWD_E_M_PC8,
		FWD_E_W_RES
	} fwd_e_t;

	typedef enum logic {
		FWD_M_ORIG,
		FWD_M_W_RES
	} fwd_m_t;

endpackage

// ==== rtl/hazard_ctrl.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module hazard_ctrl (
	input logic clk,
	input logic rst_n,
	input logic [31:0] d_instr,
	input logic d_ops_equal,
	output logic stall,
	output logic branch_taken,
	output logic jump,
	output ctrl_pkg::ext_mode_t ext_mode,
	output ctrl_pkg::alu_op_t alu_op,
	output logic alu_src_imm,
	output logic dm_we,
	output logic rf_we,
	output isa_pkg::reg_idx_t rf_waddr,
	output ctrl_pkg::wb_src_t wb_src,
	output ctrl_pkg::fwd_d_t fwd_d1,
	output ctrl_pkg::fwd_d_t fwd_d2,
	output ctrl_pkg::fwd_e_t fwd_e1,
	output ctrl_pkg::fwd_e_t fwd_e2,
	output ctrl_pkg::fwd_m_t fwd_m
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [31:0] e_instr;
	logic [31:0] m_instr;
	logic [31:0] w_instr;
	instr_kind_t d_kind;
	instr_kind_t e_kind;
	dp_class_t d_class;
	dp_class_t e_class;
	dp_class_t m_class;
	dp_class_t w_class;
	reg_idx_t d_reg1;
	reg_idx_t d_reg2;
	reg_idx_t e_reg1;
	reg_idx_t e_reg2;
	reg_idx_t e_regw;
	reg_idx_t m_reg2;
	reg_idx_t m_regw;
	reg_idx_t w_regw;
	stage_time_t d_use1;
	stage_time_t d_use2;
	stage_time_t e_new;
	stage_time_t m_new;
	stage_time_t m_new_left;
	logic stall_1;
	logic stall_2;

	instr_decode dec_d (.instr(d_instr), .kind(d_kind), .dp_class(d_class), .reg1(d_reg1),
		.reg2(d_reg2), .regw(), .t_use1(d_use1), .t_use2(d_use2), .t_new());
	instr_decode dec_e (.instr(e_instr), .kind(e_kind), .dp_class(e_class), .reg1(e_reg1),
		.reg2(e_reg2), .regw(e_regw), .t_use1(), .t_use2(), .t_new(e_new));
	instr_decode dec_m (.instr(m_instr), .kind(), .dp_class(m_class), .reg1(),
		.reg2(m_reg2), .regw(m_regw), .t_use1(), .t_use2(), .t_new(m_new));
	instr_decode dec_w (.instr(w_instr), .kind(), .dp_class(w_class), .reg1(),
		.reg2(), .regw(w_regw), .t_use1(), .t_use2(), .t_new());

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			e_instr <= 32'd0;
			m_instr <= 32'd0;
			w_instr <= 32'd0;
		end else begin
			e_instr <= stall ? 32'd0 : d_instr; // a stalled decode leaves a bubble in E.
			m_instr <= e_instr;
			w_instr <= m_instr;
		end
	end

	function automatic logic hit(input reg_idx_t src, input reg_idx_t dst);
		return (src != `REG_ZERO) && (src == dst);
	endfunction

	function automatic fwd_d_t sel_fwd_d(input reg_idx_t src);
		if (hit(src, e_regw) && e_class == C_JUMP_I) return FWD_D_E_PC8;
		if (hit(src, m_regw) && m_class == C_JUMP_I) return FWD_D_M_PC8;
		if (hit(src, m_regw) && (m_class == C_CAL_R || m_class == C_CAL_I)) return FWD_D_M_ALU;
		if (hit(src, w_regw)) return FWD_D_W_RES;
		return FWD_D_ORIG;
	endfunction

	function automatic fwd_e_t sel_fwd_e(input reg_idx_t src);
		if (hit(src, m_regw) && m_class == C_JUMP_I) return FWD_E_M_PC8;
		if (hit(src, m_regw) && (m_class == C_CAL_R || m_class == C_CAL_I)) return FWD_E_M_ALU;
		if (hit(src, w_regw)) return FWD_E_W_RES;
		return FWD_E_ORIG;
	endfunction

	assign m_new_left = (m_new != 3'd0) ? m_new - 3'd1 : 3'd0; // one cycle already spent in E.
	assign stall_1 = (hit(d_reg1, e_regw) && d_use1 < e_new) ||
		(hit(d_reg1, m_regw) && d_use1 < m_new_left);
	assign stall_2 = (hit(d_reg2, e_regw) && d_use2 < e_new) ||
		(hit(d_reg2, m_regw) && d_use2 < m_new_left);
	assign stall = stall_1 || stall_2;

	always_comb begin
		fwd_d1 = sel_fwd_d(d_reg1);
		fwd_d2 = sel_fwd_d(d_reg2);
		fwd_e1 = sel_fwd_e(e_reg1);
		fwd_e2 = sel_fwd_e(e_reg2);
		fwd_m = hit(m_reg2, w_regw) ? FWD_M_W_RES : FWD_M_ORIG;
	end

	assign branch_taken = (d_class == C_BRANCH) && d_ops_equal;
	assign jump = (d_kind == K_JAL);
	assign ext_mode = (d_kind == K_LUI) ? EXT_UPPER : (d_kind == K_ORI) ? EXT_UNSIGNED : EXT_SIGNED;
	assign alu_src_imm = e_class inside {C_CAL_I, C_LOAD, C_STORE};
	assign alu_op = (e_kind == K_SUBU) ? ALU_SUB : (e_class == C_CAL_I) ? ALU_OR : ALU_ADD;
	assign dm_we = (m_class == C_STORE);
	assign rf_we = (w_class inside {C_CAL_R, C_CAL_I, C_LOAD, C_JUMP_I}) && (w_regw != `REG_ZERO);
	assign rf_waddr = w_regw;
	assign wb_src = (w_class == C_LOAD) ? WB_MEM : (w_class == C_JUMP_I) ? WB_PC8 : WB_ALU;

	// a load feeding a branch is the longest hazard, two cycles.
	a_stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		stall ##1 stall |=> !stall);

endmodule

// ==== rtl/instr_decode.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module instr_decode (
	input logic [31:0] instr,
	output isa_pkg::instr_kind_t kind,
	output isa_pkg::dp_class_t dp_class,
	output isa_pkg::reg_idx_t reg1,
	output isa_pkg::reg_idx_t reg2,
	output isa_pkg::reg_idx_t regw,
	output isa_pkg::stage_time_t t_use1,
	output isa_pkg::stage_time_t t_use2,
	output isa_pkg::stage_time_t t_new
);
	import isa_pkg::*;

	logic [5:0] op;
	logic r_type;

	assign op = opcode_of(instr);
	assign r_type = (op == 6'h00) && (instr[10:6] == 5'd0); // shamt must be zero.

	always_comb begin
		if (instr == 32'd0) kind = K_NOP;
		else if (r_type && funct_of(instr) == 6'h21) kind = K_ADDU;
		else if (r_type && funct_of(instr) == 6'h23) kind = K_SUBU;
		else if (op == 6'h0d) kind = K_ORI;
		else if (op == 6'h0f && rs_of(instr) == `REG_ZERO) kind = K_LUI;
		else if (op == 6'h23) kind = K_LW;
		else if (op == 6'h2b) kind = K_SW;
		else if (op == 6'h04) kind = K_BEQ;
		else if (op == 6'h03) kind = K_JAL;
		else kind = K_UNKNOWN;
	end

	always_comb begin
		case (kind)
			K_ADDU, K_SUBU: dp_class = C_CAL_R;
			K_ORI, K_LUI: dp_class = C_CAL_I;
			K_LW: dp_class = C_LOAD;
			K_SW: dp_class = C_STORE;
			K_BEQ: dp_class = C_BRANCH;
			K_JAL: dp_class = C_JUMP_I;
			default: dp_class = C_NOP; // unknown words flow through as bubbles.
		endcase
	end

	always_comb begin
		reg1 = `REG_ZERO;
		reg2 = `REG_ZERO;
		regw = `REG_ZERO;
		t_use1 = `TIME_INF;
		t_use2 = `TIME_INF;
		t_new = 3'd0;
		case (dp_class)
			C_CAL_R: begin
				reg1 = rs_of(instr);
				reg2 = rt_of(instr);
				regw = rd_of(instr);
				t_use1 = 3'd1;
				t_use2 = 3'd1;
				t_new = 3'd1;
			end
			C_CAL_I, C_LOAD: begin
				reg1 = rs_of(instr);
				regw = rt_of(instr);
				t_use1 = 3'd1;
				t_new = (dp_class == C_LOAD) ? 3'd2 : 3'd1;
			end
			C_STORE: begin
				reg1 = rs_of(instr);
				reg2 = rt_of(instr);
				t_use1 = 3'd1;
				t_use2 = 3'd2; // store data is needed only in M.
			end
			C_BRANCH: begin
				reg1 = rs_of(instr);
				reg2 = rt_of(instr);
				t_use1 = 3'd0;
				t_use2 = 3'd0;
			end
			C_JUMP_I: regw = `REG_RA;
			default: ;
		endcase
	end

endmodule

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

	typedef enum logic [3:0] {
		K_ADDU,
		K_SUBU,
		K_ORI,
		K_LUI,
		K_LW,
		K_SW,
		K_BEQ,
		K_JAL,
		K_NOP,
		K_UNKNOWN
	} instr_kind_t;

	typedef enum logic [2:0] {
		C_CAL_R,
		C_CAL_I,
		C_LOAD,
		C_STORE,
		C_BRANCH,
		C_JUMP_I,
		C_NOP
	} dp_class_t;

	typedef logic [4:0] reg_idx_t;
	typedef logic [2:0] stage_time_t; // cycles until a value is used or produced.

	function automatic logic [5:0] opcode_of(input logic [31:0] instr);
		return instr[31:26];
	endfunction

	function automatic logic [5:0] funct_of(input logic [31:0] instr);
		return instr[5:0];
	endfunction

	function automatic reg_idx_t rs_of(input logic [31:0] instr);
		return instr[25:21];
	endfunction

	function automatic reg_idx_t rt_of(input logic [31:0] instr);
		return instr[20:16];
	endfunction

	function automatic reg_idx_t rd_of(input logic [31:0] instr);
		return instr[15:11];
	endfunction

endpackage

// ==== rtl/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// memory depths in 32-bit words.
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// architectural register numbers.
`define REG_ZERO 5'd0
`define REG_RA 5'd31

// Tuse of a register that the instruction never reads.
`define TIME_INF 3'd7

`endif

// ==== rtl/mips_core.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_core (
	input logic clk,
	input logic rst_n,
	input logic imem_we,
	input logic [$clog2(`IMEM_WORDS)-1:0] imem_addr,
	input logic [31:0] imem_wdata,
	output logic wb_valid,
	output isa_pkg::reg_idx_t wb_addr,
	output logic [31:0] wb_data,
	output logic st_valid,
	output logic [31:0] st_addr,
	output logic [31:0] st_data
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [31:0] d_instr;
	logic d_ops_equal;
	logic stall;
	logic branch_taken;
	logic jump;
	ext_mode_t ext_mode;
	alu_op_t alu_op;
	logic alu_src_imm;
	logic dm_we;
	logic rf_we;
	reg_idx_t rf_waddr;
	wb_src_t wb_src;
	fwd_d_t fwd_d1;
	fwd_d_t fwd_d2;
	fwd_e_t fwd_e1;
	fwd_e_t fwd_e2;
	fwd_m_t fwd_m;

	hazard_ctrl ctrl_inst (.clk(clk), .rst_n(rst_n), .d_instr(d_instr),
		.d_ops_equal(d_ops_equal), .stall(stall), .branch_taken(branch_taken), .jump(jump),
		.ext_mode(ext_mode), .alu_op(alu_op), .alu_src_imm(alu_src_imm), .dm_we(dm_we),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .wb_src(wb_src), .fwd_d1(fwd_d1),
		.fwd_d2(fwd_d2), .fwd_e1(fwd_e1), .fwd_e2(fwd_e2), .fwd_m(fwd_m));

	mips_datapath dp_inst (.clk(clk), .rst_n(rst_n), .imem_we(imem_we),
		.imem_addr(imem_addr), .imem_wdata(imem_wdata), .stall(stall),
		.branch_taken(branch_taken), .jump(jump), .ext_mode(ext_mode), .alu_op(alu_op),
		.alu_src_imm(alu_src_imm), .dm_we(dm_we), .rf_we(rf_we), .rf_waddr(rf_waddr),
		.wb_src(wb_src), .fwd_d1(fwd_d1), .fwd_d2(fwd_d2), .fwd_e1(fwd_e1), .fwd_e2(fwd_e2),
		.fwd_m(fwd_m), .d_instr(d_instr), .d_ops_equal(d_ops_equal), .wb_valid(wb_valid),
		.wb_addr(wb_addr), .wb_data(wb_data), .st_valid(st_valid), .st_addr(st_addr),
		.st_data(st_data));

endmodule

// ==== rtl/mips_datapath.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_datapath (
	input logic clk,
	input logic rst_n,
	input logic imem_we,
	input logic [$clog2(`IMEM_WORDS)-1:0] imem_addr,
	input logic [31:0] imem_wdata,
	input logic stall,
	input logic branch_taken,
	input logic jump,
	input ctrl_pkg::ext_mode_t ext_mode,
	input ctrl_pkg::alu_op_t alu_op,
	input logic alu_src_imm,
	input logic dm_we,
	input logic rf_we,
	input isa_pkg::reg_idx_t rf_waddr,
	input ctrl_pkg::wb_src_t wb_src,
	input ctrl_pkg::fwd_d_t fwd_d1,
	input ctrl_pkg::fwd_d_t fwd_d2,
	input ctrl_pkg::fwd_e_t fwd_e1,
	input ctrl_pkg::fwd_e_t fwd_e2,
	input ctrl_pkg::fwd_m_t fwd_m,
	output logic [31:0] d_instr,
	output logic d_ops_equal,
	output logic wb_valid,
	output isa_pkg::reg_idx_t wb_addr,
	output logic [31:0] wb_data,
	output logic st_valid,
	output logic [31:0] st_addr,
	output logic [31:0] st_data
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	localparam int IMEM_AW = $clog2(`IMEM_WORDS);
	localparam int DMEM_AW = $clog2(`DMEM_WORDS);

	logic [31:0] imem [`IMEM_WORDS];
	logic [31:0] dmem [`DMEM_WORDS];
	logic [31:0] pc;
	logic [31:0] fd_pc;
	logic [31:0] rf_rdata1;
	logic [31:0] rf_rdata2;
	logic [31:0] d_op1;
	logic [31:0] d_op2;
	logic [31:0] d_imm;
	logic [31:0] d_pc4;
	logic [31:0] de_op1;
	logic [31:0] de_op2;
	logic [31:0] de_imm;
	logic [31:0] de_pc8;
	logic [31:0] e_op1;
	logic [31:0] e_op2;
	logic [31:0] alu_b;
	logic [31:0] alu_y;
	logic [31:0] em_alu;
	logic [31:0] em_st_data;
	logic [31:0] em_pc8;
	logic [31:0] m_st_data;
	logic [31:0] mw_alu;
	logic [31:0] mw_mem;
	logic [31:0] mw_pc8;
	logic [31:0] w_result;

	function automatic logic [31:0] pick_d(input fwd_d_t sel, input logic [31:0] orig);
		case (sel)
			FWD_D_E_PC8: return de_pc8;
			FWD_D_M_ALU: return em_alu;
			FWD_D_M_PC8: return em_pc8;
			FWD_D_W_RES: return w_result;
			default: return orig;
		endcase
	endfunction

	function automatic logic [31:0] pick_e(input fwd_e_t sel, input logic [31:0] orig);
		case (sel)
			FWD_E_M_ALU: return em_alu;
			FWD_E_M_PC8: return em_pc8;
			FWD_E_W_RES: return w_result;
			default: return orig;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (imem_we) imem[imem_addr] <= imem_wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= 32'd0;
			d_instr <= 32'd0;
		end else if (!stall) begin
			d_instr <= imem[pc[IMEM_AW+1:2]];
			if (jump) pc <= {d_pc4[31:28], d_instr[25:0], 2'b00};
			else if (branch_taken) pc <= d_pc4 + {{14{d_instr[15]}}, d_instr[15:0], 2'b00};
			else pc <= pc + 32'd4; // the delay slot is already in fetch when D redirects.
		end
	end

	reg_file rf_inst (.clk(clk), .rst_n(rst_n), .raddr1(rs_of(d_instr)), .raddr2(rt_of(d_instr)),
		.waddr(rf_waddr), .we(rf_we), .wdata(w_result), .rdata1(rf_rdata1), .rdata2(rf_rdata2));

	always_comb begin
		d_op1 = pick_d(fwd_d1, rf_rdata1);
		d_op2 = pick_d(fwd_d2, rf_rdata2);
		e_op1 = pick_e(fwd_e1, de_op1);
		e_op2 = pick_e(fwd_e2, de_op2);
		case (ext_mode)
			EXT_UPPER: d_imm = {d_instr[15:0], 16'd0};
			EXT_UNSIGNED: d_imm = {16'd0, d_instr[15:0]};
			default: d_imm = {{16{d_instr[15]}}, d_instr[15:0]};
		endcase
		case (alu_op)
			ALU_SUB: alu_y = e_op1 - alu_b;
			ALU_OR: alu_y = e_op1 | alu_b;
			default: alu_y = e_op1 + alu_b;
		endcase
		case (wb_src)
			WB_MEM: w_result = mw_mem;
			WB_PC8: w_result = mw_pc8;
			default: w_result = mw_alu;
		endcase
	end

	assign d_pc4 = fd_pc + 32'd4;
	assign d_ops_equal = (d_op1 == d_op2);
	assign alu_b = alu_src_imm ? de_imm : e_op2;
	assign m_st_data = (fwd_m == FWD_M_W_RES) ? w_result : em_st_data;

	always_ff @(posedge clk) begin
		if (!stall) fd_pc <= pc;
		de_op1 <= d_op1;
		de_op2 <= d_op2;
		de_imm <= d_imm;
		de_pc8 <= fd_pc + 32'd8;
		em_alu <= alu_y;
		em_st_data <= e_op2;
		em_pc8 <= de_pc8;
		mw_alu <= em_alu;
		mw_mem <= dmem[em_alu[DMEM_AW+1:2]];
		mw_pc8 <= em_pc8;
		if (dm_we) dmem[em_alu[DMEM_AW+1:2]] <= m_st_data;
	end

	assign wb_valid = rf_we;
	assign wb_addr = rf_waddr;
	assign wb_data = w_result;
	assign st_valid = dm_we;
	assign st_addr = em_alu;
	assign st_data = m_st_data;

	a_store_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		st_valid |-> st_addr[31:2] < `DMEM_WORDS);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module reg_file (
	input logic clk,
	input logic rst_n,
	input logic [4:0] raddr1,
	input logic [4:0] raddr2,
	input logic [4:0] waddr,
	input logic we,
	input logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);
	logic [31:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (we && waddr != `REG_ZERO) begin
			regs[waddr] <= wdata;
		end
	end

	// no internal bypass. A same-cycle read returns the old contents.
	assign rdata1 = (raddr1 == `REG_ZERO) ? 32'd0 : regs[raddr1];
	assign rdata2 = (raddr2 == `REG_ZERO) ? 32'd0 : regs[raddr2];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_core -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
	echo "FAIL: no result line in $LOG"
	exit 1
fi
echo "PASS"
exit 0

// ==== tb.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/hazard_ctrl.sv
rtl/mips_datapath.sv
rtl/mips_core.sv
tests/tb_mips_core.sv

// ==== tests/tb_mips_core.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module tb_mips_core;

	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam int WAIT_LIMIT = 400;

	logic clk;
	logic rst_n;
	logic imem_we;
	logic [5:0] imem_addr;
	logic [31:0] imem_wdata;
	logic wb_valid;
	logic [4:0] wb_addr;
	logic [31:0] wb_data;
	logic st_valid;
	logic [31:0] st_addr;
	logic [31:0] st_data;

	integer seed;
	int errors;
	int checks;
	int errors_at_start;
	int checks_at_start;
	int reset_pulses;
	int run_cycle;
	int prog_len;
	int loop_idx;
	logic [31:0] prog [`IMEM_WORDS];
	logic [31:0] model_regs [32];
	logic [31:0] model_mem [`DMEM_WORDS];
	logic [4:0] exp_wb_addr [$];
	logic [31:0] exp_wb_data [$];
	logic [31:0] exp_st_addr [$];
	logic [31:0] exp_st_data [$];
	logic [4:0] got_wb_addr [$];
	logic [31:0] got_wb_data [$];
	time got_wb_time [$];
	int got_wb_cycle [$];
	logic [31:0] got_st_addr [$];
	logic [31:0] got_st_data [$];
	time got_st_time [$];
	int got_st_cycle [$];

	mips_core mips_core_inst (.clk(clk), .rst_n(rst_n), .imem_we(imem_we),
		.imem_addr(imem_addr), .imem_wdata(imem_wdata), .wb_valid(wb_valid),
		.wb_addr(wb_addr), .wb_data(wb_data), .st_valid(st_valid), .st_addr(st_addr),
		.st_data(st_data));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// outputs are sampled mid-cycle, half a period after the driving edge.
	always @(negedge clk) begin
		if (!rst_n) begin
			run_cycle = 0;
			if (wb_valid === 1'b1 || st_valid === 1'b1) reset_pulses++;
		end else begin
			if (wb_valid) begin
				got_wb_addr.push_back(wb_addr);
				got_wb_data.push_back(wb_data);
				got_wb_time.push_back($time);
				got_wb_cycle.push_back(run_cycle);
			end
			if (st_valid) begin
				got_st_addr.push_back(st_addr);
				got_st_data.push_back(st_data);
				got_st_time.push_back($time);
				got_st_cycle.push_back(run_cycle);
			end
			run_cycle++;
		end
	end

	function automatic logic [31:0] r_word(input logic [5:0] funct, input int rd, input int rs,
		input int rt);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input int rt, input int rs,
		input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [15:0] random_half();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	task automatic clear_program();
		for (int i = 0; i < `IMEM_WORDS; i++) prog[i] = 32'd0;
		prog_len = 0;
	endtask

	task automatic append_word(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	// a self-branch with a nop delay slot parks the core at the end.
	task automatic close_program();
		loop_idx = prog_len;
		append_word(i_word(OP_BEQ, 0, 0, 16'hffff));
		append_word(32'd0);
	endtask

	task automatic model_write(input logic [4:0] idx, input logic [31:0] value);
		if (idx != 5'd0) begin
			model_regs[idx] = value;
			exp_wb_addr.push_back(idx);
			exp_wb_data.push_back(value);
		end
	endtask

	// sequential ISA execution, one delay slot after every branch and jump.
	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nxt;
		logic [31:0] ir;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ea;
		int steps;
		exp_wb_addr.delete();
		exp_wb_data.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
		pc = 32'd0;
		npc = 32'd4;
		steps = 0;
		while (pc != loop_idx * 4 && steps < 256) begin
			ir = prog[pc[7:2]];
			a = model_regs[ir[25:21]];
			b = model_regs[ir[20:16]];
			ea = a + {{16{ir[15]}}, ir[15:0]};
			nxt = npc + 32'd4;
			case (ir[31:26])
				6'h00: begin
					if (ir[10:6] == 5'd0 && ir[5:0] == FN_ADDU) model_write(ir[15:11], a + b);
					else if (ir[10:6] == 5'd0 && ir[5:0] == FN_SUBU) model_write(ir[15:11], a - b);
				end
				OP_ORI: model_write(ir[20:16], a | {16'd0, ir[15:0]});
				OP_LUI: model_write(ir[20:16], {ir[15:0], 16'd0});
				OP_LW: model_write(ir[20:16], model_mem[ea[7:2]]);
				OP_SW: begin
					model_mem[ea[7:2]] = b;
					exp_st_addr.push_back(ea);
					exp_st_data.push_back(b);
				end
				OP_BEQ: if (a == b) nxt = npc + {{14{ir[15]}}, ir[15:0], 2'b00};
				OP_JAL: begin
					model_write(5'd31, pc + 32'd8);
					nxt = {npc[31:28], ir[25:0], 2'b00};
				end
				default: ;
			endcase
			pc = npc;
			npc = nxt;
			steps++;
		end
	endtask

	task automatic clear_traces();
		got_wb_addr.delete();
		got_wb_data.delete();
		got_wb_time.delete();
		got_wb_cycle.delete();
		got_st_addr.delete();
		got_st_data.delete();
		got_st_time.delete();
		got_st_cycle.delete();
	endtask

	task automatic run_program(input string name);
		int cycles;
		errors_at_start = errors;
		checks_at_start = checks;
		@(posedge clk);
		rst_n <= 1'b0;
		for (int i = 0; i < `IMEM_WORDS; i++) begin
			@(posedge clk);
			imem_we <= 1'b1;
			imem_addr <= i[5:0];
			imem_wdata <= prog[i]; // words past the program are nops.
		end
		@(posedge clk);
		imem_we <= 1'b0;
		for (int i = 0; i < 3; i++) @(posedge clk);
		clear_traces();
		run_model();
		rst_n <= 1'b1;
		cycles = 0;
		while ((got_wb_addr.size() < exp_wb_addr.size() || got_st_addr.size() < exp_st_addr.size())
			&& cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		checks++;
		assert (got_wb_addr.size() >= exp_wb_addr.size() && got_st_addr.size() >= exp_st_addr.size())
		else begin
			$display("%s: timed out after %0d cycles waiting for the trace entries", name, cycles);
			errors++;
		end
		// spare cycles let any unexpected extra entry show up.
		for (int i = 0; i < 8; i++) @(posedge clk);
	endtask

	task automatic compare_value(input string sig, input time t, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] time %0t: %s is %h, expected %h", t, sig, got, exp);
			errors++;
		end
	endtask

	task automatic check_traces(input string name);
		checks++;
		assert (got_wb_addr.size() == exp_wb_addr.size()) else begin
			$display("%s: the DUT made %0d register writes where %0d were expected", name,
				got_wb_addr.size(), exp_wb_addr.size());
			errors++;
		end
		checks++;
		assert (got_st_addr.size() == exp_st_addr.size()) else begin
			$display("%s: the DUT made %0d stores where %0d were expected", name,
				got_st_addr.size(), exp_st_addr.size());
			errors++;
		end
		for (int i = 0; i < got_wb_addr.size() && i < exp_wb_addr.size(); i++) begin
			compare_value("wb_addr", got_wb_time[i], got_wb_addr[i], exp_wb_addr[i]);
			compare_value("wb_data", got_wb_time[i], got_wb_data[i], exp_wb_data[i]);
		end
		for (int i = 0; i < got_st_addr.size() && i < exp_st_addr.size(); i++) begin
			compare_value("st_addr", got_st_time[i], got_st_addr[i], exp_st_addr[i]);
			compare_value("st_data", got_st_time[i], got_st_data[i], exp_st_data[i]);
		end
	endtask

	task automatic report_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - checks_at_start,
			errors - errors_at_start);
	endtask

	task automatic alu_chain_test();
		clear_program();
		append_word(i_word(OP_LUI, 1, 0, random_half()));
		append_word(i_word(OP_ORI, 1, 1, random_half())); // takes $1 from the M stage.
		append_word(i_word(OP_ORI, 2, 0, random_half()));
		append_word(r_word(FN_ADDU, 3, 1, 2));
		append_word(r_word(FN_SUBU, 4, 3, 1));
		append_word(r_word(FN_ADDU, 5, 4, 3));
		append_word(r_word(FN_SUBU, 6, 5, 5));
		append_word(i_word(OP_LUI, 7, 0, random_half()));
		append_word(r_word(FN_ADDU, 7, 7, 5));
		append_word(i_word(OP_ORI, 8, 7, random_half()));
		append_word(r_word(FN_SUBU, 9, 8, 4));
		close_program();
		run_program("alu_chain");
		check_traces("alu_chain");
		report_test("alu_chain");
	endtask

	task automatic load_use_test();
		clear_program();
		append_word(i_word(OP_ORI, 10, 0, 16'h0040));
		append_word(i_word(OP_LUI, 1, 0, random_half()));
		append_word(i_word(OP_ORI, 1, 1, random_half()));
		append_word(i_word(OP_ORI, 2, 0, random_half()));
		append_word(i_word(OP_SW, 1, 10, 16'd0));
		append_word(i_word(OP_SW, 2, 10, 16'd4));
		append_word(i_word(OP_LW, 3, 10, 16'd0));
		append_word(r_word(FN_ADDU, 4, 3, 2)); // one stall cycle.
		append_word(i_word(OP_LW, 5, 10, 16'd4));
		append_word(i_word(OP_SW, 5, 10, 16'd8)); // store data comes from W.
		append_word(i_word(OP_LW, 6, 10, 16'd8));
		append_word(r_word(FN_SUBU, 7, 6, 3));
		append_word(i_word(OP_SW, 7, 10, 16'd12));
		append_word(i_word(OP_LW, 8, 10, 16'd12));
		append_word(i_word(OP_LW, 9, 10, 16'd8));
		append_word(r_word(FN_ADDU, 11, 8, 9));
		close_program();
		run_program("load_use");
		check_traces("load_use");
		report_test("load_use");
	endtask

	task automatic branch_test();
		logic [15:0] v;
		v = random_half() | 16'h8000;
		clear_program();
		append_word(i_word(OP_ORI, 1, 0, v));
		append_word(i_word(OP_ORI, 2, 0, v));
		append_word(i_word(OP_BEQ, 2, 1, 16'd3)); // taken, one stall on $2.
		append_word(i_word(OP_ORI, 3, 0, 16'h0011));
		append_word(i_word(OP_ORI, 4, 0, 16'h0022));
		append_word(i_word(OP_ORI, 5, 0, 16'h0033));
		append_word(i_word(OP_SW, 1, 0, 16'h0020));
		append_word(i_word(OP_LW, 7, 0, 16'h0020));
		append_word(i_word(OP_BEQ, 3, 7, 16'd3)); // not taken, two stalls on the load.
		append_word(r_word(FN_ADDU, 8, 7, 3));
		append_word(r_word(FN_SUBU, 9, 7, 3));
		append_word(i_word(OP_LW, 11, 0, 16'h0020));
		append_word(i_word(OP_BEQ, 1, 11, 16'd2));
		append_word(32'd0);
		append_word(i_word(OP_ORI, 12, 0, 16'h0055));
		append_word(i_word(OP_ORI, 13, 0, 16'h0066));
		close_program();
		run_program("branch");
		check_traces("branch");
		report_test("branch");
	endtask

	task automatic jal_link_test();
		clear_program();
		append_word(i_word(OP_ORI, 1, 0, random_half()));
		append_word({OP_JAL, 26'd4});
		append_word(r_word(FN_ADDU, 2, 31, 0)); // delay slot sees $31 while jal is in E.
		append_word(i_word(OP_ORI, 3, 0, 16'h0077));
		append_word(r_word(FN_ADDU, 4, 31, 1));
		append_word(r_word(FN_SUBU, 5, 31, 2));
		append_word(i_word(OP_SW, 31, 0, 16'h0030));
		close_program();
		run_program("jal_link");
		check_traces("jal_link");
		report_test("jal_link");
	endtask

	task automatic zero_reg_test();
		clear_program();
		append_word(i_word(OP_ORI, 1, 0, random_half()));
		append_word(i_word(OP_ORI, 0, 0, random_half()));
		append_word(r_word(FN_ADDU, 0, 1, 1));
		append_word(32'd0);
		append_word(r_word(FN_ADDU, 2, 0, 1));
		append_word(i_word(OP_LUI, 0, 0, random_half()));
		append_word(i_word(OP_SW, 0, 0, 16'h0038));
		append_word(r_word(FN_SUBU, 3, 1, 0));
		append_word(32'd0);
		append_word(i_word(OP_ORI, 4, 0, 16'h0005));
		close_program();
		run_program("zero_reg");
		check_traces("zero_reg");
		report_test("zero_reg");
	endtask

	// instruction k with no stalls is in M at cycle k+3 and in W at cycle k+4.
	task automatic reset_quiet_test();
		clear_program();
		append_word(i_word(OP_ORI, 1, 0, random_half()));
		append_word(i_word(OP_SW, 1, 0, 16'h003c));
		close_program();
		run_program("reset_quiet");
		check_traces("reset_quiet");
		if (got_wb_cycle.size() > 0) compare_value("wb_valid cycle", got_wb_time[0],
			got_wb_cycle[0], 32'd4);
		if (got_st_cycle.size() > 0) compare_value("st_valid cycle", got_st_time[0],
			got_st_cycle[0], 32'd4);
		checks++;
		assert (reset_pulses == 0) else begin
			$display("reset_quiet: %0d trace pulses appeared while reset was asserted", reset_pulses);
			errors++;
		end
		report_test("reset_quiet");
	endtask

	initial begin
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = 6'd0;
		imem_wdata = 32'd0;
		seed = 6389;
		errors = 0;
		checks = 0;
		reset_pulses = 0;
		run_cycle = 0;
		alu_chain_test();
		load_use_test();
		branch_test();
		jal_link_test();
		zero_reg_test();
		reset_quiet_test();
		$display("total: 6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
